//--- src/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath and address width
`define MIPS_WORD_W 32

// register file geometry
`define MIPS_REG_ADDR_W 5
`define MIPS_NUM_REGS 32

// program counter
`define MIPS_PC_RESET 32'h0000_0000
`define MIPS_PC_STEP 32'd4

// instruction field widths
`define MIPS_OPCODE_W 6
`define MIPS_FUNCT_W 6

`endif

//--- src/mipsPkg.sv
`default_nettype none

`include "mips_macros.svh"

package mipsPkg;

	typedef enum logic [`MIPS_OPCODE_W-1:0] {
		OP_FUNCT = 6'h00,	// R-type, look at funct
		OP_J = 6'h02,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_LUI = 6'h0f,
		OP_LW = 6'h23,
		OP_SW = 6'h2b
	} opcodeE;

	typedef enum logic [`MIPS_FUNCT_W-1:0] {
		FN_NOP = 6'h00,
		FN_BREAK = 6'h0d,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_XOR = 6'h26
	} functE;

	typedef enum logic [4:0] {
		S_RESET,
		S_FETCH,
		S_FETCH_MEM_DELAY1,
		S_FETCH_MEM_DELAY2,
		S_DECODE,
		S_BEQ,
		S_BNE,
		S_LW,
		S_SW,
		S_LUI,
		S_J,
		S_NOP,
		S_ADD,
		S_R_WAIT,
		S_AND,
		S_SUB,
		S_XOR,
		S_BREAK,
		S_LW_ADDRESS_COMP,
		S_SW_ADDRESS_COMP,
		S_WRITE_BACK,
		S_LW_DELAY1,
		S_LW_DELAY2
	} stateE;

	typedef enum logic [2:0] {
		ALU_PASS = 3'd0,
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_XOR = 3'd6
	} aluOpE;

	typedef enum logic [1:0] {
		SRCB_REG_B = 2'd0,
		SRCB_CONST_STEP = 2'd1,
		SRCB_SIGN_IMM = 2'd2,
		SRCB_SIGN_IMM_SHIFTED = 2'd3
	} aluSrcBE;

	typedef enum logic [1:0] {
		MTR_ALU_OUT = 2'd0,
		MTR_MEM_DATA = 2'd1,
		MTR_UPPER_IMM = 2'd2
	} memToRegE;

	typedef enum logic {
		DST_RT = 1'b0,
		DST_RD = 1'b1
	} regDstE;

	typedef enum logic [1:0] {
		PCSRC_ALU_RESULT = 2'd0,
		PCSRC_ALU_OUT = 2'd1,
		PCSRC_JUMP_TARGET = 2'd2
	} pcSourceE;

	typedef enum logic {
		ADDR_PC = 1'b0,
		ADDR_ALU_OUT = 1'b1
	} addrSelE;

endpackage : mipsPkg

`default_nettype wire

//--- src/mipsControl.sv
`timescale 1ns/1ps
`default_nettype none

module mipsControl
	import mipsPkg::*;
(
	input logic Clk,
	input logic Reset_signal,
	input opcodeE Op,
	input functE Funct,		// only meaningful when Op is OP_FUNCT
	input logic AluZero,
	output logic PcLoad,
	output logic IrWrite,
	output logic AbLoad,
	output logic MdrLoad,
	output logic AluOutLoad,
	output logic RegWrite,
	output logic MemWrite,
	output logic Halted,
	output aluOpE AluOp,
	output logic AluSrcA,		// 0 selects PC, 1 selects A
	output aluSrcBE AluSrcB,
	output memToRegE MemToReg,
	output regDstE RegDst,
	output pcSourceE PcSource,
	output addrSelE AddrSel
);

	stateE state;

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			state <= S_RESET;
		else
		begin
			case (state)
				S_RESET: state <= S_FETCH;
				S_FETCH: state <= S_FETCH_MEM_DELAY1;
				S_FETCH_MEM_DELAY1: state <= S_FETCH_MEM_DELAY2;
				S_FETCH_MEM_DELAY2: state <= S_DECODE;
				S_DECODE:
				begin
					case (Op)
						OP_FUNCT:
						begin
							case (Funct)
								FN_ADD: state <= S_ADD;
								FN_SUB: state <= S_SUB;
								FN_AND: state <= S_AND;
								FN_XOR: state <= S_XOR;
								FN_NOP: state <= S_NOP;
								default: state <= S_BREAK;	// BREAK and unknown funct
							endcase
						end
						OP_BEQ: state <= S_BEQ;
						OP_BNE: state <= S_BNE;
						OP_LW: state <= S_LW_ADDRESS_COMP;
						OP_SW: state <= S_SW_ADDRESS_COMP;
						OP_LUI: state <= S_LUI;
						OP_J: state <= S_J;
						default: state <= S_BREAK;	// undefined opcode halts
					endcase
				end
				S_ADD, S_SUB, S_AND, S_XOR: state <= S_R_WAIT;
				S_LW_ADDRESS_COMP: state <= S_LW;
				S_LW: state <= S_LW_DELAY1;
				S_LW_DELAY1: state <= S_LW_DELAY2;
				S_LW_DELAY2: state <= S_WRITE_BACK;
				S_SW_ADDRESS_COMP: state <= S_SW;
				S_BREAK: state <= S_BREAK;	// stays until reset
				S_R_WAIT, S_BEQ, S_BNE, S_J, S_LUI, S_NOP, S_SW, S_WRITE_BACK:
					state <= S_FETCH;
				default: state <= S_RESET;
			endcase
		end
	end

	assign Halted = (state == S_BREAK);

	always_comb
	begin
		PcLoad = 1'b0;
		IrWrite = 1'b0;
		AbLoad = 1'b0;
		MdrLoad = 1'b0;
		AluOutLoad = 1'b0;
		RegWrite = 1'b0;
		MemWrite = 1'b0;
		AluOp = ALU_PASS;
		AluSrcA = 1'b0;
		AluSrcB = SRCB_REG_B;
		MemToReg = MTR_ALU_OUT;
		RegDst = DST_RT;
		PcSource = PCSRC_ALU_RESULT;
		AddrSel = ADDR_PC;

		case (state)
			S_FETCH_MEM_DELAY2:
			begin
				IrWrite = 1'b1;		// word at PC is on MemRdata now
				PcLoad = 1'b1;
				AluOp = ALU_ADD;		// PC + 4
				AluSrcB = SRCB_CONST_STEP;
			end
			S_DECODE:
			begin
				AbLoad = 1'b1;
				AluOutLoad = 1'b1;		// branch target, in case it is needed
				AluOp = ALU_ADD;
				AluSrcB = SRCB_SIGN_IMM_SHIFTED;
			end
			S_ADD, S_SUB, S_AND, S_XOR:
			begin
				AluSrcA = 1'b1;
				AluOutLoad = 1'b1;
				case (state)
					S_SUB: AluOp = ALU_SUB;
					S_AND: AluOp = ALU_AND;
					S_XOR: AluOp = ALU_XOR;
					default: AluOp = ALU_ADD;
				endcase
			end
			S_R_WAIT:
			begin
				RegWrite = 1'b1;
				RegDst = DST_RD;
			end
			S_BEQ, S_BNE:
			begin
				AluSrcA = 1'b1;		// A - B
				AluOp = ALU_SUB;
				PcSource = PCSRC_ALU_OUT;
				PcLoad = (state == S_BNE) ? !AluZero : AluZero;
			end
			S_J:
			begin
				PcLoad = 1'b1;
				PcSource = PCSRC_JUMP_TARGET;
			end
			S_LUI:
			begin
				RegWrite = 1'b1;		// rt gets imm << 16
				MemToReg = MTR_UPPER_IMM;
			end
			S_LW_ADDRESS_COMP, S_SW_ADDRESS_COMP:
			begin
				AluSrcA = 1'b1;		// A + offset
				AluSrcB = SRCB_SIGN_IMM;
				AluOp = ALU_ADD;
				AluOutLoad = 1'b1;
			end
			S_LW, S_LW_DELAY1:
				AddrSel = ADDR_ALU_OUT;
			S_LW_DELAY2:
			begin
				AddrSel = ADDR_ALU_OUT;
				MdrLoad = 1'b1;		// read data valid here
			end
			S_SW:
			begin
				AddrSel = ADDR_ALU_OUT;
				MemWrite = 1'b1;
			end
			S_WRITE_BACK:
			begin
				RegWrite = 1'b1;
				MemToReg = MTR_MEM_DATA;
			end
			default:
			begin
			end
		endcase
	end

endmodule : mipsControl

`default_nettype wire

//--- src/mipsRegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mipsRegFile
(
	input logic Clk,
	input logic Reset_signal,
	input logic RegWrite,
	input logic [`MIPS_REG_ADDR_W-1:0] ReadAddrA,
	input logic [`MIPS_REG_ADDR_W-1:0] ReadAddrB,
	input logic [`MIPS_REG_ADDR_W-1:0] WriteAddr,
	input logic [`MIPS_WORD_W-1:0] WriteData,
	output logic [`MIPS_WORD_W-1:0] ReadDataA,
	output logic [`MIPS_WORD_W-1:0] ReadDataB
);

	logic [`MIPS_WORD_W-1:0] regs [`MIPS_NUM_REGS];

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
		begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (RegWrite && (WriteAddr != '0))	// $zero is read-only
			regs[WriteAddr] <= WriteData;
	end

	// combinational reads, $zero forced low
	assign ReadDataA = (ReadAddrA == '0) ? '0 : regs[ReadAddrA];
	assign ReadDataB = (ReadAddrB == '0) ? '0 : regs[ReadAddrB];

endmodule : mipsRegFile

`default_nettype wire

//--- src/mipsAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mipsAlu
	import mipsPkg::*;
(
	input aluOpE AluOp,
	input logic AluSrcA,
	input aluSrcBE AluSrcB,
	input logic [`MIPS_WORD_W-1:0] Pc,
	input logic [`MIPS_WORD_W-1:0] RegA,
	input logic [`MIPS_WORD_W-1:0] RegB,
	input logic [`MIPS_WORD_W-1:0] SignImm,
	output logic [`MIPS_WORD_W-1:0] AluResult,
	output logic AluZero
);

	logic [`MIPS_WORD_W-1:0] opA;
	logic [`MIPS_WORD_W-1:0] opB;

	assign opA = AluSrcA ? RegA : Pc;

	always_comb
	begin
		case (AluSrcB)
			SRCB_CONST_STEP: opB = `MIPS_PC_STEP;
			SRCB_SIGN_IMM: opB = SignImm;
			SRCB_SIGN_IMM_SHIFTED: opB = {SignImm[`MIPS_WORD_W-3:0], 2'b00};	// word offset
			default: opB = RegB;
		endcase
	end

	always_comb
	begin
		case (AluOp)
			ALU_ADD: AluResult = opA + opB;
			ALU_SUB: AluResult = opA - opB;
			ALU_AND: AluResult = opA & opB;
			ALU_XOR: AluResult = opA ^ opB;
			default: AluResult = '0;	// pass
		endcase
	end

	assign AluZero = (AluResult == '0);	// used for beq/bne

endmodule : mipsAlu

`default_nettype wire

//--- src/mipsDataRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mipsDataRegs
	import mipsPkg::*;
(
	input logic Clk,
	input logic Reset_signal,
	input logic IrWrite,
	input logic AbLoad,
	input logic MdrLoad,
	input logic AluOutLoad,
	input memToRegE MemToReg,
	input regDstE RegDst,
	input logic [`MIPS_WORD_W-1:0] MemRdata,
	input logic [`MIPS_WORD_W-1:0] ReadDataA,
	input logic [`MIPS_WORD_W-1:0] ReadDataB,
	input logic [`MIPS_WORD_W-1:0] AluResult,
	output logic [`MIPS_WORD_W-1:0] Instr,
	output logic [`MIPS_WORD_W-1:0] RegA,
	output logic [`MIPS_WORD_W-1:0] RegB,
	output logic [`MIPS_WORD_W-1:0] AluOut,
	output logic [`MIPS_WORD_W-1:0] SignImm,
	output logic [`MIPS_REG_ADDR_W-1:0] WriteAddr,
	output logic [`MIPS_WORD_W-1:0] WriteData
);

	logic [`MIPS_WORD_W-1:0] mdr;
	logic [15:0] imm;

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
		begin
			Instr <= '0;
			RegA <= '0;
			RegB <= '0;
			mdr <= '0;
			AluOut <= '0;
		end
		else
		begin
			if (IrWrite)
				Instr <= MemRdata;
			if (AbLoad)
			begin
				RegA <= ReadDataA;		// rs
				RegB <= ReadDataB;		// rt
			end
			if (MdrLoad)
				mdr <= MemRdata;
			if (AluOutLoad)
				AluOut <= AluResult;
		end
	end

	assign imm = Instr[15:0];
	assign SignImm = {{(`MIPS_WORD_W-16){imm[15]}}, imm};

	// rd for R-type, rt otherwise
	assign WriteAddr = (RegDst == DST_RD) ? Instr[15:11] : Instr[20:16];

	always_comb
	begin
		case (MemToReg)
			MTR_MEM_DATA: WriteData = mdr;
			MTR_UPPER_IMM: WriteData = {imm, {(`MIPS_WORD_W-16){1'b0}}};	// lui
			default: WriteData = AluOut;
		endcase
	end

endmodule : mipsDataRegs

`default_nettype wire

//--- src/mipsPcUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mipsPcUnit
	import mipsPkg::*;
(
	input logic Clk,
	input logic Reset_signal,
	input logic PcLoad,
	input pcSourceE PcSource,
	input logic [`MIPS_WORD_W-1:0] AluResult,
	input logic [`MIPS_WORD_W-1:0] AluOut,
	input logic [`MIPS_WORD_W-1:0] Instr,
	output logic [`MIPS_WORD_W-1:0] Pc
);

	logic [`MIPS_WORD_W-1:0] jumpTarget;
	logic [`MIPS_WORD_W-1:0] nextPc;

	// region of PC+4, then 26-bit index as word address
	assign jumpTarget = {Pc[`MIPS_WORD_W-1 -: 4], Instr[25:0], 2'b00};

	always_comb
	begin
		case (PcSource)
			PCSRC_ALU_OUT: nextPc = AluOut;	// branch target from decode
			PCSRC_JUMP_TARGET: nextPc = jumpTarget;
			default: nextPc = AluResult;		// sequential
		endcase
	end

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			Pc <= `MIPS_PC_RESET;
		else if (PcLoad)
			Pc <= nextPc;
	end

endmodule : mipsPcUnit

`default_nettype wire

//--- src/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mipsCore
	import mipsPkg::*;
(
	input logic Clk,
	input logic Reset_signal,
	input logic [`MIPS_WORD_W-1:0] MemRdata,
	output logic [`MIPS_WORD_W-1:0] MemAddr,
	output logic [`MIPS_WORD_W-1:0] MemWdata,
	output logic MemWrite,
	output logic Halted
);

	logic pcLoad, irWrite, abLoad, mdrLoad, aluOutLoad, regWrite;
	logic aluSrcA, aluZero;
	aluOpE aluOp;
	aluSrcBE aluSrcB;
	memToRegE memToReg;
	regDstE regDst;
	pcSourceE pcSource;
	addrSelE addrSel;
	opcodeE op;
	functE funct;
	logic [`MIPS_WORD_W-1:0] pc, instr, regA, regB, aluOut, aluResult, signImm;
	logic [`MIPS_WORD_W-1:0] readDataA, readDataB, writeData;
	logic [`MIPS_REG_ADDR_W-1:0] writeAddr;

	assign op = opcodeE'(instr[31:26]);
	assign funct = functE'(instr[5:0]);

	mipsControl control0 (.Clk(Clk), .Reset_signal(Reset_signal), .Op(op), .Funct(funct),
		.AluZero(aluZero), .PcLoad(pcLoad), .IrWrite(irWrite), .AbLoad(abLoad),
		.MdrLoad(mdrLoad), .AluOutLoad(aluOutLoad), .RegWrite(regWrite), .MemWrite(MemWrite),
		.Halted(Halted), .AluOp(aluOp), .AluSrcA(aluSrcA), .AluSrcB(aluSrcB),
		.MemToReg(memToReg), .RegDst(regDst), .PcSource(pcSource), .AddrSel(addrSel));

	mipsRegFile regFile0 (.Clk(Clk), .Reset_signal(Reset_signal), .RegWrite(regWrite),
		.ReadAddrA(instr[25:21]), .ReadAddrB(instr[20:16]), .WriteAddr(writeAddr),
		.WriteData(writeData), .ReadDataA(readDataA), .ReadDataB(readDataB));

	mipsAlu alu0 (.AluOp(aluOp), .AluSrcA(aluSrcA), .AluSrcB(aluSrcB), .Pc(pc),
		.RegA(regA), .RegB(regB), .SignImm(signImm), .AluResult(aluResult),
		.AluZero(aluZero));

	mipsDataRegs dataRegs0 (.Clk(Clk), .Reset_signal(Reset_signal), .IrWrite(irWrite),
		.AbLoad(abLoad), .MdrLoad(mdrLoad), .AluOutLoad(aluOutLoad), .MemToReg(memToReg),
		.RegDst(regDst), .MemRdata(MemRdata), .ReadDataA(readDataA), .ReadDataB(readDataB),
		.AluResult(aluResult), .Instr(instr), .RegA(regA), .RegB(regB), .AluOut(aluOut),
		.SignImm(signImm), .WriteAddr(writeAddr), .WriteData(writeData));

	mipsPcUnit pcUnit0 (.Clk(Clk), .Reset_signal(Reset_signal), .PcLoad(pcLoad),
		.PcSource(pcSource), .AluResult(aluResult), .AluOut(aluOut), .Instr(instr),
		.Pc(pc));

	// instruction fetch from PC, data access from ALUOut
	assign MemAddr = (addrSel == ADDR_ALU_OUT) ? aluOut : pc;
	assign MemWdata = regB;	// sw stores rt

endmodule : mipsCore

`default_nettype wire

//--- verification/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb
	import mipsPkg::*;
();

	localparam int numRows = 20;
	localparam int memWords = 256;
	localparam int resetCycles = 8;
	localparam int haltTimeout = 200;
	localparam int holdCycles = 20;
	localparam int kindRtype = 0;
	localparam int kindBranch = 1;
	localparam int kindLui = 2;
	localparam int kindJump = 3;
	localparam int kindHalt = 4;
	localparam logic [31:0] marker1 = 32'h1111_0000;
	localparam logic [31:0] marker2 = 32'h2222_0000;
	localparam logic [31:0] breakWord = {26'b0, FN_BREAK};

	logic Clk;
	logic Reset_signal;
	logic [31:0] MemRdata;
	logic [31:0] MemAddr;
	logic [31:0] MemWdata;
	logic MemWrite;
	logic Halted;

	logic [31:0] mem [memWords];
	logic [31:0] readWord;
	logic [31:0] lfsrState;
	int kindTab [numRows];
	int subTab [numRows];
	logic [31:0] aTab [numRows];
	logic [31:0] bTab [numRows];
	logic [31:0] exp108Tab [numRows];
	logic [31:0] exp10cTab [numRows];
	int errors;
	int checks;

	mipsCore dut0 (.Clk(Clk), .Reset_signal(Reset_signal), .MemRdata(MemRdata),
		.MemAddr(MemAddr), .MemWdata(MemWdata), .MemWrite(MemWrite), .Halted(Halted));

	always #2 Clk = ~Clk;

	// one cycle read latency with the write at the edge
	always @(posedge Clk)
	begin
		readWord = mem[MemAddr[9:2]];
		if (MemWrite)
			mem[MemAddr[9:2]] = MemWdata;
		MemRdata <= #1 readWord;
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'hA5C3_0F96;
	endfunction

	function automatic logic [31:0] encodeImm(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeReg(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {OP_FUNCT, rs, rt, rd, 5'b0, fn};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic putWord(input logic [31:0] addr, input logic [31:0] data);
		mem[addr[9:2]] = data;
	endtask

	task automatic buildTable();
		logic taken;
		for (int i = 0; i < numRows; i++)
		begin
			kindTab[i] = i % 5;
			subTab[i] = (i / 5) % 4;
			aTab[i] = randomBits(32);
			bTab[i] = randomBits(32);
			exp108Tab[i] = fillWord(32'h108);	// untouched unless stored
			exp10cTab[i] = fillWord(32'h10C);
			case (kindTab[i])
				kindRtype:
				begin
					case (subTab[i])
						0: exp108Tab[i] = aTab[i] + bTab[i];
						1: exp108Tab[i] = aTab[i] - bTab[i];
						2: exp108Tab[i] = aTab[i] & bTab[i];
						default: exp108Tab[i] = aTab[i] ^ bTab[i];
					endcase
				end
				kindBranch:
				begin
					if (subTab[i] % 2 == 0)
						bTab[i] = aTab[i];		// equal operands
					taken = (subTab[i] < 2) ? (aTab[i] == bTab[i]) : (aTab[i] != bTab[i]);
					if (!taken)
						exp108Tab[i] = marker1;
					exp10cTab[i] = marker2;
				end
				kindLui:
				begin
					exp108Tab[i] = {aTab[i][15:0], 16'h0000};
					exp10cTab[i] = '0;		// store of $zero
				end
				kindJump: exp10cTab[i] = marker2;
				default:
				begin
				end
			endcase
		end
	endtask

	task automatic loadProgram(input int row);
		logic [5:0] fn;
		logic [5:0] branchOp;
		for (int i = 0; i < memWords; i++)
			mem[i] = fillWord(i * 4);
		putWord(32'h100, aTab[row]);
		putWord(32'h104, bTab[row]);
		case (kindTab[row])
			kindRtype:
			begin
				case (subTab[row])
					0: fn = FN_ADD;
					1: fn = FN_SUB;
					2: fn = FN_AND;
					default: fn = FN_XOR;
				endcase
				putWord(32'h00, encodeImm(OP_LW, 0, 1, 16'h0100));
				putWord(32'h04, encodeImm(OP_LW, 0, 2, 16'h0104));
				putWord(32'h08, encodeReg(1, 2, 3, fn));
				putWord(32'h0C, encodeImm(OP_SW, 0, 3, 16'h0108));
				putWord(32'h10, breakWord);
			end
			kindBranch:
			begin
				branchOp = (subTab[row] < 2) ? OP_BEQ : OP_BNE;
				putWord(32'h00, encodeImm(OP_LW, 0, 1, 16'h0100));
				putWord(32'h04, encodeImm(OP_LW, 0, 2, 16'h0104));
				putWord(32'h08, encodeImm(OP_LUI, 0, 5, marker1[31:16]));
				putWord(32'h0C, encodeImm(OP_LUI, 0, 6, marker2[31:16]));
				putWord(32'h10, encodeImm(branchOp, 1, 2, 16'h0001));	// skips one word
				putWord(32'h14, encodeImm(OP_SW, 0, 5, 16'h0108));
				putWord(32'h18, encodeImm(OP_SW, 0, 6, 16'h010C));
				putWord(32'h1C, breakWord);
			end
			kindLui:
			begin
				putWord(32'h00, encodeImm(OP_LUI, 0, 4, aTab[row][15:0]));
				putWord(32'h04, encodeImm(OP_SW, 0, 4, 16'h0108));
				putWord(32'h08, encodeImm(OP_SW, 0, 0, 16'h010C));
				putWord(32'h0C, breakWord);
			end
			kindJump:
			begin
				putWord(32'h00, encodeImm(OP_LUI, 0, 5, marker1[31:16]));
				putWord(32'h04, encodeImm(OP_LUI, 0, 6, marker2[31:16]));
				putWord(32'h08, {OP_J, 26'd5});		// target 0x14
				putWord(32'h0C, encodeImm(OP_SW, 0, 5, 16'h0108));
				putWord(32'h10, breakWord);
				putWord(32'h14, 32'h0000_0000);
				putWord(32'h18, 32'h0000_0000);
				putWord(32'h1C, encodeImm(OP_SW, 0, 6, 16'h010C));
				putWord(32'h20, breakWord);
			end
			kindHalt:
			begin
				case (subTab[row])
					1: putWord(32'h00, {6'h3f, 26'b0});		// undefined opcode
					2: putWord(32'h00, {OP_FUNCT, 20'b0, 6'h3f});	// undefined funct
					default: putWord(32'h00, breakWord);
				endcase
			end
		endcase
	endtask

	task automatic applyReset();
		@(posedge Clk);
		#1;
		Reset_signal = 1'b1;
		repeat (resetCycles)
		begin
			@(negedge Clk);
			checkValue("MemWrite", MemWrite, 0);
			checkValue("Halted", Halted, 0);
			checkValue("MemAddr", MemAddr, 32'h0);
			@(posedge Clk);
			#1;
		end
		Reset_signal = 1'b0;
		@(negedge Clk);		// RESET state
		checkValue("MemWrite", MemWrite, 0);
		checkValue("Halted", Halted, 0);
		checkValue("MemAddr", MemAddr, 32'h0);
	endtask

	task automatic waitForHalt(input int row, output bit seen);
		int cycles;
		seen = 0;
		cycles = 0;
		while (!seen && cycles < haltTimeout)
		begin
			@(negedge Clk);
			if (Halted === 1'b1)
				seen = 1;
			cycles++;
		end
		if (!seen)
		begin
			errors++;
			$display("timeout: the core did not halt within %0d cycles on row %0d",
				haltTimeout, row);
		end
	endtask

	task automatic checkHaltHold();
		logic [31:0] haltAddr;
		haltAddr = MemAddr;
		repeat (holdCycles)
		begin
			@(negedge Clk);
			checkValue("Halted", Halted, 1);
			checkValue("MemWrite", MemWrite, 0);
			checkValue("MemAddr", MemAddr, haltAddr);
		end
	endtask

	initial
	begin
		bit seen;
		Clk = 1'b0;
		Reset_signal = 1'b1;
		MemRdata = '0;
		errors = 0;
		checks = 0;
		lfsrState = 32'h4182;
		buildTable();
		for (int row = 0; row < numRows; row++)
		begin
			loadProgram(row);
			applyReset();
			waitForHalt(row, seen);
			if (seen)
			begin
				checkHaltHold();
				checkValue("mem[0x108]", mem[32'h108 >> 2], exp108Tab[row]);
				checkValue("mem[0x10C]", mem[32'h10C >> 2], exp10cTab[row]);
			end
		end
		$display("rows: %0d, checks: %0d, errors: %0d", numRows, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : mipsCoreTb

`default_nettype wire

//--- files.f
+incdir+src
src/mipsPkg.sv
src/mipsControl.sv
src/mipsRegFile.sv
src/mipsAlu.sv
src/mipsDataRegs.sv
src/mipsPcUnit.sv
src/mipsCore.sv
verification/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - src

sources:
  - src/mipsPkg.sv
  - src/mipsControl.sv
  - src/mipsRegFile.sv
  - src/mipsAlu.sv
  - src/mipsDataRegs.sv
  - src/mipsPcUnit.sv
  - src/mipsCore.sv
  - target: test
    files:
      - verification/mipsCoreTb.sv
